/* common/disk_defines.svh */
`ifndef DISK_DEFINES_SVH
`define DISK_DEFINES_SVH

// Hard-disk units served by the router
`define DISK_HDD_UNITS 2

// Block-device indices offered by the host
`define DISK_BLK_DEVS 4

// Index owned by the 3.5-inch floppy controller
`define DISK_WOZ_INDEX 2

// Field widths on the host side
`define DISK_LBA_W 32
`define DISK_BUF_ADDR_W 9
`define DISK_BYTE_W 8
`define DISK_SIZE_W 64

// Sector number width from the core
`define DISK_SECTOR_W 16

`endif

/* common/blk_pkg.sv */
`default_nettype none

`include "disk_defines.svh"

// Types of the host block-device side
package blk_pkg;

	// Block address sent with each strobe
	typedef logic [`DISK_LBA_W-1:0] blk_lba_t;

	// Address inside one sector buffer
	typedef logic [`DISK_BUF_ADDR_W-1:0] blk_buf_addr_t;

	// One byte of sector-buffer data
	typedef logic [`DISK_BYTE_W-1:0] blk_byte_t;

	// One bit per host index
	typedef logic [`DISK_BLK_DEVS-1:0] blk_dev_mask_t;

	// Image size reported with a mount pulse
	typedef logic [`DISK_SIZE_W-1:0] blk_img_size_t;

endpackage

`default_nettype wire

/* common/hdd_pkg.sv */
`default_nettype none

`include "disk_defines.svh"

// Types of the core's hard-disk request side
package hdd_pkg;

	typedef logic [`DISK_SECTOR_W-1:0] hdd_sector_t;

	// Unit number, one bit for two units
	typedef logic [$clog2(`DISK_HDD_UNITS)-1:0] hdd_unit_t;

	// Per-unit status bits
	typedef logic [`DISK_HDD_UNITS-1:0] hdd_unit_mask_t;

	// Transfer machine states
	typedef enum logic {xfer_idle, xfer_busy} hdd_xfer_state_t;

endpackage

`default_nettype wire

/* disk_io/hdd_req_decode.sv */
`default_nettype none

// Request capture for the hard-disk units
// Strobes from the core are one cycle wide, so they are held here
// until the transfer machine reports the end of the host transfer
module hdd_req_decode (
	input wire clk_sys,
	input wire reset,

	// One-cycle request strobes from the core
	input wire hdd_read,
	input wire hdd_write,
	input wire hdd_pkg::hdd_unit_t hdd_unit,

	// Feedback from the transfer machine
	input wire xfer_busy,
	input wire xfer_done,

	output logic read_pending,
	output logic write_pending,
	output hdd_pkg::hdd_unit_t active_unit
);

	logic any_pending;
	logic new_request;
	logic latch_unit;

	assign any_pending = read_pending | write_pending;
	assign new_request = hdd_read | hdd_write;

	// Unit is taken only from the first request of a transfer
	assign latch_unit = new_request & ~xfer_busy & ~any_pending;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			read_pending <= 1'b0;
			write_pending <= 1'b0;
		end else if (xfer_done) begin
			// End of transfer wins over a strobe in the same cycle
			read_pending <= 1'b0;
			write_pending <= 1'b0;
		end else begin
			// Sticky flags, requests while busy accumulate here
			read_pending <= read_pending | hdd_read;
			write_pending <= write_pending | hdd_write;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			active_unit <= '0;
		end else if (latch_unit) begin
			active_unit <= hdd_unit;
		end
	end

endmodule

`default_nettype wire

/* disk_io/hdd_xfer_exec.sv */
`default_nettype none

// Transfer machine for the hard-disk side
// Idle picks up the pending flags, busy follows the host acknowledge
module hdd_xfer_exec (
	input wire clk_sys,
	input wire reset,

	input wire read_pending,
	input wire write_pending,

	// Acknowledge of the active unit's index
	input wire active_ack,

	// Strobes before routing to an index
	output logic hd_rd,
	output logic hd_wr,

	// Holds the CPU for the whole transfer
	output logic cpu_wait,
	output logic xfer_busy,
	output logic xfer_done
);

	hdd_pkg::hdd_xfer_state_t state;

	// Previous acknowledge, for edge detection
	logic ack_d;
	logic ack_rise;
	logic ack_fall;

	assign ack_rise = ~ack_d & active_ack;
	assign ack_fall = ack_d & ~active_ack;

	assign xfer_busy = (state == hdd_pkg::xfer_busy);

	// Single-cycle pulse, clears the pending flags in the decoder
	assign xfer_done = xfer_busy & ack_fall;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ack_d <= 1'b0;
		end else begin
			ack_d <= active_ack;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= hdd_pkg::xfer_idle;
			hd_rd <= 1'b0;
			hd_wr <= 1'b0;
			cpu_wait <= 1'b0;
		end else begin
			case (state)
				hdd_pkg::xfer_idle: begin
					// Read and write pending together issue both strobes
					if (read_pending | write_pending) begin
						state <= hdd_pkg::xfer_busy;
						hd_rd <= read_pending;
						hd_wr <= write_pending;
						cpu_wait <= 1'b1;
					end
				end
				hdd_pkg::xfer_busy: begin
					if (ack_rise) begin
						// Host has taken the request
						hd_rd <= 1'b0;
						hd_wr <= 1'b0;
					end else if (ack_fall) begin
						state <= hdd_pkg::xfer_idle;
						cpu_wait <= 1'b0;
					end
				end
				default: state <= hdd_pkg::xfer_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

/* disk_io/blk_route_result.sv */
`default_nettype none

`include "disk_defines.svh"

// Routing between the core and the host indices, plus disk status
module blk_route_result (
	input wire clk_sys,
	input wire reset,

	// Hard-disk transfer
	input wire hdd_pkg::hdd_unit_t active_unit,
	input wire hd_rd,
	input wire hd_wr,
	input wire hdd_pkg::hdd_sector_t hdd_sector,

	// Floppy controller
	input wire blk_pkg::blk_lba_t woz_lba,
	input wire woz_rd,
	input wire woz_wr,

	// Host side
	input wire blk_pkg::blk_dev_mask_t sd_ack,
	input wire blk_pkg::blk_dev_mask_t img_mounted,
	input wire img_readonly,
	input wire blk_pkg::blk_img_size_t img_size,
	input wire sd_buff_wr,

	// Buffer read data
	input wire blk_pkg::blk_byte_t hdd_ram_do,
	input wire blk_pkg::blk_byte_t woz_buff_din,

	output logic active_ack,
	output blk_pkg::blk_dev_mask_t sd_rd,
	output blk_pkg::blk_dev_mask_t sd_wr,
	output blk_pkg::blk_lba_t sd_lba0,
	output blk_pkg::blk_lba_t sd_lba1,
	output blk_pkg::blk_lba_t sd_lba2,
	output blk_pkg::blk_lba_t sd_lba3,
	output blk_pkg::blk_byte_t sd_buff_din0,
	output blk_pkg::blk_byte_t sd_buff_din1,
	output blk_pkg::blk_byte_t sd_buff_din2,
	output blk_pkg::blk_byte_t sd_buff_din3,
	output logic hdd_ram_we,
	output hdd_pkg::hdd_unit_mask_t hdd_mounted,
	output hdd_pkg::hdd_unit_mask_t hdd_protect,
	output logic woz_mount
);

	blk_pkg::blk_lba_t lba_sel [`DISK_BLK_DEVS];
	blk_pkg::blk_byte_t din_sel [`DISK_BLK_DEVS];
	logic woz_mounted_d;
	logic img_present;

	// Acknowledge of the unit being served
	assign active_ack = sd_ack[active_unit];

	// Host buffer writes reach the disk RAM only during our transfer
	assign hdd_ram_we = sd_buff_wr & active_ack;

	assign img_present = (img_size != '0);

	always_comb begin
		for (int i = 0; i < `DISK_BLK_DEVS; i++) begin
			if (i < `DISK_HDD_UNITS) begin
				// Units share sector and RAM, only the strobe is steered
				sd_rd[i] = hd_rd & (int'(active_unit) == i);
				sd_wr[i] = hd_wr & (int'(active_unit) == i);
				lba_sel[i] = blk_pkg::blk_lba_t'(hdd_sector);
				din_sel[i] = hdd_ram_do;
			end else if (i == `DISK_WOZ_INDEX) begin
				sd_rd[i] = woz_rd;
				sd_wr[i] = woz_wr;
				lba_sel[i] = woz_lba;
				din_sel[i] = woz_buff_din;
			end else begin
				// Spare index stays quiet
				sd_rd[i] = 1'b0;
				sd_wr[i] = 1'b0;
				lba_sel[i] = '0;
				din_sel[i] = '0;
			end
		end
	end

	assign sd_lba0 = lba_sel[0];
	assign sd_lba1 = lba_sel[1];
	assign sd_lba2 = lba_sel[2];
	assign sd_lba3 = lba_sel[3];
	assign sd_buff_din0 = din_sel[0];
	assign sd_buff_din1 = din_sel[1];
	assign sd_buff_din2 = din_sel[2];
	assign sd_buff_din3 = din_sel[3];

	// Unit status follows every mount pulse on its index
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			hdd_mounted <= '0;
			hdd_protect <= '0;
		end else begin
			for (int u = 0; u < `DISK_HDD_UNITS; u++) begin
				if (img_mounted[u]) begin
					hdd_mounted[u] <= img_present;
					hdd_protect[u] <= img_readonly;
				end
			end
		end
	end

	// Floppy mount level from the rising edge of its pulse
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			woz_mounted_d <= 1'b0;
			woz_mount <= 1'b0;
		end else begin
			woz_mounted_d <= img_mounted[`DISK_WOZ_INDEX];
			if (~woz_mounted_d & img_mounted[`DISK_WOZ_INDEX])
				woz_mount <= img_present;
		end
	end

endmodule

`default_nettype wire

/* disk_io/disk_io_top.sv */
`default_nettype none

// Virtual-disk request router, between the core and the host service
module disk_io_top (
	input wire clk_sys,
	input wire reset,

	// Core hard-disk requests
	input wire hdd_read,
	input wire hdd_write,
	input wire hdd_pkg::hdd_unit_t hdd_unit,
	input wire hdd_pkg::hdd_sector_t hdd_sector,
	output logic cpu_wait,

	// Floppy controller
	input wire blk_pkg::blk_lba_t woz_lba,
	input wire woz_rd,
	input wire woz_wr,
	input wire blk_pkg::blk_byte_t woz_buff_din,
	output logic woz_mount,

	// Host block-device service
	input wire blk_pkg::blk_dev_mask_t sd_ack,
	input wire blk_pkg::blk_dev_mask_t img_mounted,
	input wire img_readonly,
	input wire blk_pkg::blk_img_size_t img_size,
	input wire sd_buff_wr,
	output blk_pkg::blk_dev_mask_t sd_rd,
	output blk_pkg::blk_dev_mask_t sd_wr,
	output blk_pkg::blk_lba_t sd_lba0,
	output blk_pkg::blk_lba_t sd_lba1,
	output blk_pkg::blk_lba_t sd_lba2,
	output blk_pkg::blk_lba_t sd_lba3,
	output blk_pkg::blk_byte_t sd_buff_din0,
	output blk_pkg::blk_byte_t sd_buff_din1,
	output blk_pkg::blk_byte_t sd_buff_din2,
	output blk_pkg::blk_byte_t sd_buff_din3,

	// Hard-disk sector RAM and status
	input wire blk_pkg::blk_byte_t hdd_ram_do,
	output logic hdd_ram_we,
	output hdd_pkg::hdd_unit_mask_t hdd_mounted,
	output hdd_pkg::hdd_unit_mask_t hdd_protect
);

	logic read_pending;
	logic write_pending;
	hdd_pkg::hdd_unit_t active_unit;
	logic xfer_busy;
	logic xfer_done;
	logic active_ack;
	logic hd_rd;
	logic hd_wr;

	// Decode, latches requests and the unit
	hdd_req_decode u_decode (
		.clk_sys(clk_sys),
		.reset(reset),
		.hdd_read(hdd_read),
		.hdd_write(hdd_write),
		.hdd_unit(hdd_unit),
		.xfer_busy(xfer_busy),
		.xfer_done(xfer_done),
		.read_pending(read_pending),
		.write_pending(write_pending),
		.active_unit(active_unit)
	);

	// Execute, runs the acknowledge handshake
	hdd_xfer_exec u_exec (
		.clk_sys(clk_sys),
		.reset(reset),
		.read_pending(read_pending),
		.write_pending(write_pending),
		.active_ack(active_ack),
		.hd_rd(hd_rd),
		.hd_wr(hd_wr),
		.cpu_wait(cpu_wait),
		.xfer_busy(xfer_busy),
		.xfer_done(xfer_done)
	);

	// Result, index routing and status
	blk_route_result u_result (
		.clk_sys(clk_sys),
		.reset(reset),
		.active_unit(active_unit),
		.hd_rd(hd_rd),
		.hd_wr(hd_wr),
		.hdd_sector(hdd_sector),
		.woz_lba(woz_lba),
		.woz_rd(woz_rd),
		.woz_wr(woz_wr),
		.sd_ack(sd_ack),
		.img_mounted(img_mounted),
		.img_readonly(img_readonly),
		.img_size(img_size),
		.sd_buff_wr(sd_buff_wr),
		.hdd_ram_do(hdd_ram_do),
		.woz_buff_din(woz_buff_din),
		.active_ack(active_ack),
		.sd_rd(sd_rd),
		.sd_wr(sd_wr),
		.sd_lba0(sd_lba0),
		.sd_lba1(sd_lba1),
		.sd_lba2(sd_lba2),
		.sd_lba3(sd_lba3),
		.sd_buff_din0(sd_buff_din0),
		.sd_buff_din1(sd_buff_din1),
		.sd_buff_din2(sd_buff_din2),
		.sd_buff_din3(sd_buff_din3),
		.hdd_ram_we(hdd_ram_we),
		.hdd_mounted(hdd_mounted),
		.hdd_protect(hdd_protect),
		.woz_mount(woz_mount)
	);

endmodule

`default_nettype wire

/* sim/disk_io_chk.sv */
`default_nettype none

`include "disk_defines.svh"

// Handshake properties of the router bound into disk_io_top
module disk_io_chk (
	input wire clk_sys,
	input wire reset,
	input wire active_ack,
	input wire cpu_wait,
	input wire blk_pkg::blk_dev_mask_t sd_rd,
	input wire blk_pkg::blk_dev_mask_t sd_wr
);

	timeunit 1ns;
	timeprecision 100ps;

	logic [`DISK_HDD_UNITS-1:0] hdd_strobes;
	logic any_strobe;

	// Number of property failures so far
	int assert_fails = 0;

	// Read and write of one unit share its index
	assign hdd_strobes = sd_rd[`DISK_HDD_UNITS-1:0] | sd_wr[`DISK_HDD_UNITS-1:0];
	assign any_strobe = |hdd_strobes;

	// Host acknowledge takes the strobe down on the next edge
	strobe_drops_after_ack: assert property (@(posedge clk_sys) disable iff (reset)
		any_strobe && $rose(active_ack) |=> !any_strobe)
		else begin
			assert_fails++;
			$error("Hard-disk strobe still high one cycle after acknowledge rose");
		end

	// CPU is held for as long as a request is out
	wait_covers_strobe: assert property (@(posedge clk_sys) disable iff (reset)
		any_strobe |-> cpu_wait)
		else begin
			assert_fails++;
			$error("Hard-disk strobe high while cpu_wait is low");
		end

	single_hdd_index: assert property (@(posedge clk_sys) disable iff (reset)
		$onehot0(hdd_strobes))
		else begin
			assert_fails++;
			$error("More than one hard-disk index strobed at once");
		end

endmodule

bind disk_io_top disk_io_chk u_chk (
	.clk_sys(clk_sys),
	.reset(reset),
	.active_ack(active_ack),
	.cpu_wait(cpu_wait),
	.sd_rd(sd_rd),
	.sd_wr(sd_wr)
);

`default_nettype wire

/* sim/disk_io_tb.sv */
`default_nettype none

`include "disk_defines.svh"

// Testbench for the virtual-disk router
// Test lines come from sim/disk_io_tests.txt and a host model answers the hard-disk strobes
module disk_io_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 10;
	localparam int DRIVE_DELAY = 2;
	// Host model limits in cycles
	localparam int MAX_ACK_DELAY = 6;
	localparam int MAX_ACK_HOLD = 4;
	localparam int TEST_MARGIN = 10;
	localparam int MAX_TESTS = 64;
	localparam int WORDS_PER_TEST = 6;

	// Operation codes of the first column
	localparam logic [63:0] OP_READ = 64'h1;
	localparam logic [63:0] OP_WRITE = 64'h2;
	localparam logic [63:0] OP_MOUNT = 64'h3;
	localparam logic [63:0] OP_WOZ_RD = 64'h4;
	localparam logic [63:0] OP_WOZ_MOUNT = 64'h5;
	localparam logic [63:0] OP_WOZ_WR = 64'h6;
	localparam logic [63:0] OP_END = 64'hff;

	logic clk_sys;
	logic reset;
	logic hdd_read;
	logic hdd_write;
	hdd_pkg::hdd_unit_t hdd_unit;
	hdd_pkg::hdd_sector_t hdd_sector;
	logic cpu_wait;
	blk_pkg::blk_lba_t woz_lba;
	logic woz_rd;
	logic woz_wr;
	blk_pkg::blk_byte_t woz_buff_din;
	logic woz_mount;
	blk_pkg::blk_dev_mask_t sd_ack;
	blk_pkg::blk_dev_mask_t img_mounted;
	logic img_readonly;
	blk_pkg::blk_img_size_t img_size;
	logic sd_buff_wr;
	blk_pkg::blk_dev_mask_t sd_rd;
	blk_pkg::blk_dev_mask_t sd_wr;
	blk_pkg::blk_lba_t sd_lba0;
	blk_pkg::blk_lba_t sd_lba1;
	blk_pkg::blk_lba_t sd_lba2;
	blk_pkg::blk_lba_t sd_lba3;
	blk_pkg::blk_byte_t sd_buff_din0;
	blk_pkg::blk_byte_t sd_buff_din1;
	blk_pkg::blk_byte_t sd_buff_din2;
	blk_pkg::blk_byte_t sd_buff_din3;
	blk_pkg::blk_byte_t hdd_ram_do;
	logic hdd_ram_we;
	hdd_pkg::hdd_unit_mask_t hdd_mounted;
	hdd_pkg::hdd_unit_mask_t hdd_protect;

	// Six words per test line
	logic [63:0] test_mem [MAX_TESTS*WORDS_PER_TEST];
	int num_tests;
	int checks;
	int value_errors;
	int other_errors;
	logic tests_loaded;
	int unsigned seed_ret;

	disk_io_top dut (
		.clk_sys(clk_sys),
		.reset(reset),
		.hdd_read(hdd_read),
		.hdd_write(hdd_write),
		.hdd_unit(hdd_unit),
		.hdd_sector(hdd_sector),
		.cpu_wait(cpu_wait),
		.woz_lba(woz_lba),
		.woz_rd(woz_rd),
		.woz_wr(woz_wr),
		.woz_buff_din(woz_buff_din),
		.woz_mount(woz_mount),
		.sd_ack(sd_ack),
		.img_mounted(img_mounted),
		.img_readonly(img_readonly),
		.img_size(img_size),
		.sd_buff_wr(sd_buff_wr),
		.sd_rd(sd_rd),
		.sd_wr(sd_wr),
		.sd_lba0(sd_lba0),
		.sd_lba1(sd_lba1),
		.sd_lba2(sd_lba2),
		.sd_lba3(sd_lba3),
		.sd_buff_din0(sd_buff_din0),
		.sd_buff_din1(sd_buff_din1),
		.sd_buff_din2(sd_buff_din2),
		.sd_buff_din3(sd_buff_din3),
		.hdd_ram_do(hdd_ram_do),
		.hdd_ram_we(hdd_ram_we),
		.hdd_mounted(hdd_mounted),
		.hdd_protect(hdd_protect)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD/2) clk_sys = ~clk_sys;
	end

	task automatic check_value(input string name, input logic [63:0] actual,
			input logic [63:0] expected);
		checks++;
		assert (actual === expected) else begin
			value_errors++;
			$display("[ERROR] %0d ns %s: got %0h, expected %0h",
				$time, name, actual, expected);
		end
	endtask

	task automatic print_summary();
		$display("Summary: %0d tests %0d checks, errors %0d value %0d other %0d assertion",
			num_tests, checks, value_errors, other_errors, dut.u_chk.assert_fails);
	endtask

	// Outputs that reset must hold low
	task automatic check_quiet_outputs();
		check_value("cpu_wait", 64'(cpu_wait), 64'h0);
		check_value("sd_rd", 64'(sd_rd), 64'h0);
		check_value("sd_wr", 64'(sd_wr), 64'h0);
		check_value("hdd_mounted", 64'(hdd_mounted), 64'h0);
		check_value("hdd_protect", 64'(hdd_protect), 64'h0);
		check_value("woz_mount", 64'(woz_mount), 64'h0);
	endtask

	// One hard-disk request through the whole acknowledge handshake
	task automatic run_hdd_transfer(input logic is_write, input hdd_pkg::hdd_unit_t unit,
			input hdd_pkg::hdd_sector_t sector, input logic [63:0] exp_mask,
			input logic [63:0] exp_lba);
		blk_pkg::blk_dev_mask_t ack_mask;
		ack_mask = blk_pkg::blk_dev_mask_t'(1) << unit;
		@(posedge clk_sys);
		#DRIVE_DELAY;
		hdd_ram_do = blk_pkg::blk_byte_t'($urandom);
		hdd_unit = unit;
		hdd_sector = sector;
		hdd_read = ~is_write;
		hdd_write = is_write;
		@(posedge clk_sys);
		#DRIVE_DELAY;
		hdd_read = 1'b0;
		hdd_write = 1'b0;
		// Pending flag set on the strobe edge
		// Wait and index strobe follow one edge later
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_value("cpu_wait", 64'(cpu_wait), 64'h1);
		check_value("sd_rd", 64'(sd_rd), is_write ? 64'h0 : exp_mask);
		check_value("sd_wr", 64'(sd_wr), is_write ? exp_mask : 64'h0);
		check_value("sd_lba0", 64'(sd_lba0), exp_lba);
		check_value("sd_lba1", 64'(sd_lba1), exp_lba);
		check_value("sd_lba3", 64'(sd_lba3), 64'h0);
		while ((sd_ack & ack_mask) == '0) begin
			@(negedge clk_sys);
		end
		check_value("hdd_ram_we", 64'(hdd_ram_we), 64'(sd_buff_wr));
		// Strobe gone one edge after the acknowledge
		@(negedge clk_sys);
		check_value("sd_rd", 64'(sd_rd), 64'h0);
		check_value("sd_wr", 64'(sd_wr), 64'h0);
		while ((sd_ack & ack_mask) != '0) begin
			check_value("hdd_ram_we", 64'(hdd_ram_we), 64'(sd_buff_wr));
			check_value("sd_buff_din0", 64'(sd_buff_din0), 64'(hdd_ram_do));
			check_value("sd_buff_din1", 64'(sd_buff_din1), 64'(hdd_ram_do));
			@(negedge clk_sys);
		end
		// Falling acknowledge seen on the next edge
		check_value("cpu_wait", 64'(cpu_wait), 64'h1);
		@(negedge clk_sys);
		check_value("cpu_wait", 64'(cpu_wait), 64'h0);
	endtask

	task automatic pulse_mount(input blk_pkg::blk_dev_mask_t mask,
			input blk_pkg::blk_img_size_t size, input logic readonly);
		@(posedge clk_sys);
		#DRIVE_DELAY;
		img_mounted = mask;
		img_size = size;
		img_readonly = readonly;
		@(posedge clk_sys);
		#DRIVE_DELAY;
		img_mounted = '0;
		@(negedge clk_sys);
	endtask

	// Floppy strobe and address straight through to index 2
	task automatic run_woz_access(input logic is_write, input blk_pkg::blk_lba_t lba,
			input logic [63:0] exp_mask, input logic [63:0] exp_lba);
		@(posedge clk_sys);
		#DRIVE_DELAY;
		woz_lba = lba;
		woz_rd = ~is_write;
		woz_wr = is_write;
		woz_buff_din = blk_pkg::blk_byte_t'($urandom);
		@(negedge clk_sys);
		check_value("sd_rd", 64'(sd_rd), is_write ? 64'h0 : exp_mask);
		check_value("sd_wr", 64'(sd_wr), is_write ? exp_mask : 64'h0);
		check_value("sd_lba2", 64'(sd_lba2), exp_lba);
		check_value("sd_buff_din2", 64'(sd_buff_din2), 64'(woz_buff_din));
		check_value("sd_buff_din3", 64'(sd_buff_din3), 64'h0);
		@(posedge clk_sys);
		#DRIVE_DELAY;
		woz_rd = 1'b0;
		woz_wr = 1'b0;
	endtask

	// Host model for the hard-disk indices
	initial begin : host_model
		blk_pkg::blk_dev_mask_t ack_mask;
		int delay;
		int hold;
		sd_ack = '0;
		sd_buff_wr = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (!reset && ((sd_rd[`DISK_HDD_UNITS-1:0]
					| sd_wr[`DISK_HDD_UNITS-1:0]) != '0)) begin
				ack_mask = (sd_rd[1] | sd_wr[1]) ? 4'b0010 : 4'b0001;
				delay = $urandom_range(MAX_ACK_DELAY, 1);
				hold = $urandom_range(MAX_ACK_HOLD, 2);
				repeat (delay) @(posedge clk_sys);
				#DRIVE_DELAY;
				sd_ack = sd_ack | ack_mask;
				// Random buffer writes during the acknowledge
				repeat (hold) begin
					sd_buff_wr = 1'($urandom_range(1, 0));
					@(posedge clk_sys);
					#DRIVE_DELAY;
				end
				sd_buff_wr = 1'b0;
				sd_ack = sd_ack & ~ack_mask;
			end
		end
	end

	initial begin : watchdog
		longint limit_ns;
		wait (tests_loaded === 1'b1);
		limit_ns = longint'(RESET_CYCLES + TEST_MARGIN
			+ num_tests * (MAX_ACK_DELAY + MAX_ACK_HOLD + TEST_MARGIN)) * CLK_PERIOD;
		#(limit_ns);
		other_errors++;
		$display("Timeout: the tests did not finish within %0d ns", limit_ns);
		print_summary();
		$display("TEST FAILED");
		$finish;
	end

	initial begin : main_sequence
		int base;
		logic [63:0] op;
		hdd_pkg::hdd_unit_t unit;
		blk_pkg::blk_dev_mask_t mask;
		seed_ret = $urandom(32'h312e);
		reset = 1'b1;
		hdd_read = 1'b0;
		hdd_write = 1'b0;
		hdd_unit = '0;
		hdd_sector = '0;
		woz_lba = '0;
		woz_rd = 1'b0;
		woz_wr = 1'b0;
		woz_buff_din = '0;
		img_mounted = '0;
		img_readonly = 1'b0;
		img_size = '0;
		hdd_ram_do = '0;
		checks = 0;
		value_errors = 0;
		other_errors = 0;
		num_tests = 0;
		tests_loaded = 1'b0;
		for (int i = 0; i < MAX_TESTS*WORDS_PER_TEST; i++) begin
			test_mem[i] = '1;
		end
		$readmemh("sim/disk_io_tests.txt", test_mem);
		// Count lines up to the end marker
		while (num_tests < MAX_TESTS && test_mem[num_tests*WORDS_PER_TEST] != OP_END
				&& test_mem[num_tests*WORDS_PER_TEST] !== '1) begin
			num_tests++;
		end
		if (num_tests == 0) begin
			other_errors++;
			$display("No test lines were found in sim/disk_io_tests.txt");
		end
		tests_loaded = 1'b1;
		repeat (RESET_CYCLES) begin
			@(negedge clk_sys);
			check_quiet_outputs();
		end
		@(posedge clk_sys);
		#DRIVE_DELAY;
		reset = 1'b0;
		@(negedge clk_sys);
		check_quiet_outputs();
		for (int t = 0; t < num_tests; t++) begin
			base = t * WORDS_PER_TEST;
			op = test_mem[base];
			unit = hdd_pkg::hdd_unit_t'(test_mem[base+1]);
			case (op)
				OP_READ, OP_WRITE: begin
					run_hdd_transfer(op == OP_WRITE, unit,
						hdd_pkg::hdd_sector_t'(test_mem[base+2]),
						test_mem[base+4], test_mem[base+5]);
				end
				OP_MOUNT: begin
					mask = blk_pkg::blk_dev_mask_t'(1) << unit;
					pulse_mount(mask, blk_pkg::blk_img_size_t'(test_mem[base+2]),
						test_mem[base+3][0]);
					check_value("hdd_mounted", 64'(hdd_mounted), test_mem[base+4]);
					check_value("hdd_protect", 64'(hdd_protect), test_mem[base+5]);
				end
				OP_WOZ_RD, OP_WOZ_WR: begin
					run_woz_access(op == OP_WOZ_WR, blk_pkg::blk_lba_t'(test_mem[base+2]),
						test_mem[base+4], test_mem[base+5]);
				end
				OP_WOZ_MOUNT: begin
					mask = blk_pkg::blk_dev_mask_t'(1) << `DISK_WOZ_INDEX;
					pulse_mount(mask, blk_pkg::blk_img_size_t'(test_mem[base+2]),
						test_mem[base+3][0]);
					check_value("woz_mount", 64'(woz_mount), test_mem[base+4]);
				end
				default: begin
					other_errors++;
					$display("Test line %0d has an unknown operation code %0h", t, op);
				end
			endcase
		end
		print_summary();
		if (value_errors == 0 && other_errors == 0 && dut.u_chk.assert_fails == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sim/disk_io_tests.txt */
// Columns: op unit value readonly exp_a exp_b, all hex
// op 1 read, 2 write (value sector, exp_a strobe mask, exp_b lba); 3 mount (value size,
// exp_a mounted, exp_b protect); 4 woz read, 6 woz write (value lba, exp_a strobe mask,
// exp_b lba); 5 woz mount (value size, exp_a woz_mount); ff ends the list
1 0 0123 0 1 00000123
1 1 beef 0 2 0000beef
2 1 4000 0 2 00004000
2 0 0001 0 1 00000001
3 0 100000 1 1 1
3 1 200 0 3 1
3 0 0 0 2 0
3 1 0 1 0 2
4 0 12345678 0 4 12345678
6 0 0abcdef0 0 4 0abcdef0
5 0 8000 0 1 0
5 0 0 0 0 0
5 0 400 0 1 0
1 1 ffff 0 2 0000ffff
2 0 7fff 0 1 00007fff
2 1 0a5a 0 2 00000a5a
1 0 0000 0 1 00000000
ff 0 0 0 0 0

/* list.f */
+incdir+common
common/blk_pkg.sv
common/hdd_pkg.sv
disk_io/hdd_req_decode.sv
disk_io/hdd_xfer_exec.sv
disk_io/blk_route_result.sv
disk_io/disk_io_top.sv
sim/disk_io_chk.sv
sim/disk_io_tb.sv

/* Makefile */
TOP := disk_io_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) \
		--Mdir obj_dir -o disk_io_sim
	@out="$$(./obj_dir/disk_io_sim 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir
